// File: design/burst_reader.sv
`default_nettype none

`include "la_cfg.svh"

module burst_reader (
    input  wire                      clk_ip,
    input  wire                      rst_n,
    input  wire [`LA_ADDR_W:0]       wr_ptr,
    input  wire                      flushed,
    input  wire                      out_credit,
    input  wire                      read_done,
    output logic                     out_valid,
    output la_types_pkg::word_t      out_data,
    output logic                     read_idle,
    store_if.reader                  store
);
    import la_types_pkg::*;
    import la_ctrl_pkg::*;

    rd_state_e           state;
    logic [`LA_ADDR_W:0] rd_ptr;
    logic [`LA_ADDR_W:0] avail;
    credit_t             credits;
    burst_len_t          left;
    burst_len_t          want_len;
    logic                start;
    logic                issue;

    assign avail    = wr_ptr - rd_ptr;
    assign want_len = (avail >= `LA_BURST_MAX) ? burst_len_t'(`LA_BURST_MAX) : burst_len_t'(avail);
    // whole burst must fit in the consumer's free slots
    assign start    = (state == RD_IDLE) && flushed && (rd_ptr < wr_ptr) &&
                      (credits >= want_len);
    assign issue    = (state == RD_BURST);

    assign store.rd_en   = issue;
    assign store.rd_addr = rd_ptr[`LA_ADDR_W-1:0];

    assign out_valid = store.rd_valid;
    assign out_data  = store.rd_data;
    assign read_idle = (state == RD_IDLE) && flushed && (rd_ptr == wr_ptr) && !store.rd_valid;

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            state  <= RD_IDLE;
            left   <= '0;
            rd_ptr <= '0;
        end else if (read_done) begin
            state  <= RD_IDLE;
            left   <= '0;
            rd_ptr <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (start) begin
                        left  <= want_len;
                        state <= RD_BURST;
                    end
                end
                RD_BURST: begin
                    rd_ptr <= rd_ptr + 1'b1;
                    left   <= left - 1'b1;
                    if (left == burst_len_t'(1)) state <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // credits survive read_done since words already sent still come back
    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_t'(`LA_OUT_CREDITS);
        end else begin
            case ({out_credit, issue})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk_ip) disable iff (!rst_n)
        credits <= `LA_OUT_CREDITS);

endmodule

`default_nettype wire

// File: design/burst_writer.sv
`default_nettype none

`include "la_cfg.svh"

module burst_writer (
    input  wire                      clk_ip,
    input  wire                      rst_n,
    input  wire                      word_valid,
    input  wire la_types_pkg::word_t word,
    input  wire                      capture_done,
    input  wire                      read_done,
    output logic [`LA_ADDR_W:0]      wr_ptr,
    output logic                     flushed,
    store_if.writer                  store
);
    import la_types_pkg::*;
    import la_ctrl_pkg::*;

    localparam int PTR_W = $clog2(`LA_INGRESS_DEPTH);

    word_t            ingress [`LA_INGRESS_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   fill;
    wr_state_e        state;
    burst_len_t       left;
    burst_len_t       start_len;
    logic             start;
    logic             pop;
    logic             full;

    assign full      = (fill == `LA_INGRESS_DEPTH);
    assign start_len = (fill >= `LA_BURST_MAX) ? burst_len_t'(`LA_BURST_MAX) : burst_len_t'(fill);
    // full burst, or whatever is left once capture ends
    assign start     = (state == WR_IDLE) &&
                       ((fill >= `LA_BURST_MAX) || (capture_done && fill != '0));
    assign pop       = (state == WR_BURST);

    assign store.wr_en   = pop;
    assign store.wr_addr = wr_ptr[`LA_ADDR_W-1:0];
    assign store.wr_data = ingress[head];

    // nothing in flight toward the store
    assign flushed = capture_done && (fill == '0) && !word_valid;

    always_ff @(posedge clk_ip) begin
        if (word_valid) ingress[tail] <= word;
    end

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            state  <= WR_IDLE;
            left   <= '0;
            head   <= '0;
            tail   <= '0;
            fill   <= '0;
            wr_ptr <= '0;
        end else if (read_done) begin
            state  <= WR_IDLE;
            left   <= '0;
            head   <= '0;
            tail   <= '0;
            fill   <= '0;
            wr_ptr <= '0;
        end else begin
            if (word_valid) tail <= tail + 1'b1;
            if (pop) begin
                head   <= head + 1'b1;
                wr_ptr <= wr_ptr + 1'b1;
            end
            case ({word_valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
            case (state)
                WR_IDLE: begin
                    if (start) begin
                        left  <= start_len;
                        state <= WR_BURST;
                    end
                end
                WR_BURST: begin
                    left <= left - 1'b1;
                    if (left == burst_len_t'(1)) state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // packer rate is far below the drain rate
    assert property (@(posedge clk_ip) disable iff (!rst_n)
        word_valid |-> !full);

endmodule

`default_nettype wire

// File: design/la_cfg.svh
`ifndef LA_CFG_SVH
`define LA_CFG_SVH

// sample and store word geometry
`define LA_SAMPLE_W          8
`define LA_WORD_W            32
`define LA_SAMPLES_PER_WORD  4

// on-chip sample store
`define LA_ADDR_W            10
`define LA_STORE_DEPTH       1024

`define LA_BURST_MAX         8     // words per burst in both directions
`define LA_OUT_CREDITS       8     // consumer slots held after reset
`define LA_INGRESS_DEPTH     16

`endif

// File: design/la_ctrl_pkg.sv
`default_nettype none

package la_ctrl_pkg;

    typedef enum logic [1:0] {
        IMMEDIATE,
        RISING,
        FALLING,
        HIGH
    } trig_mode_e;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_ARMED,   // waiting for trigger
        CAP_RUN,
        CAP_DONE
    } cap_state_e;

    typedef enum logic {
        WR_IDLE,
        WR_BURST
    } wr_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_BURST
    } rd_state_e;

endpackage

`default_nettype wire

// File: design/la_types_pkg.sv
`default_nettype none

`include "la_cfg.svh"

package la_types_pkg;

    typedef logic [`LA_SAMPLE_W-1:0] sample_t;
    typedef logic [`LA_WORD_W-1:0]   word_t;
    typedef logic [`LA_ADDR_W-1:0]   addr_t;

    // holds 1 to 8 so needs the extra bit
    typedef logic [$clog2(`LA_BURST_MAX):0] burst_len_t;

    // enough samples to fill the whole store
    typedef logic [`LA_ADDR_W+$clog2(`LA_SAMPLES_PER_WORD)-1:0] sample_cnt_t;

    typedef logic [3:0]                        rate_div_t;  // tick every div+1 cycles
    typedef logic [$clog2(`LA_SAMPLE_W)-1:0]   chan_sel_t;
    typedef logic [$clog2(`LA_OUT_CREDITS):0]  credit_t;

endpackage

`default_nettype wire

// File: design/logic_analyzer_top.sv
`default_nettype none

`include "la_cfg.svh"

module logic_analyzer_top (
    input  wire                            clk_ip,
    input  wire                            rst_n,
    input  wire                            sample_run,
    input  wire                            read_done,
    input  wire la_types_pkg::rate_div_t   rate_div,
    input  wire la_types_pkg::sample_cnt_t sample_num,
    input  wire [1:0]                      trig_mode,
    input  wire la_types_pkg::chan_sel_t   trig_chan,
    input  wire la_types_pkg::sample_t     din,
    input  wire                            out_credit,
    output wire                            out_valid,
    output wire la_types_pkg::word_t       out_data,
    output wire                            capture_done,
    output wire                            read_idle
);
    import la_types_pkg::*;

    logic                word_valid;
    word_t               word;
    logic [`LA_ADDR_W:0] wr_ptr;   // words committed
    logic                flushed;

    store_if store_bus ();

    sample_capture u_capture (
        .clk_ip       (clk_ip),
        .rst_n        (rst_n),
        .sample_run   (sample_run),
        .read_done    (read_done),
        .rate_div     (rate_div),
        .sample_num   (sample_num),
        .trig_mode    (la_ctrl_pkg::trig_mode_e'(trig_mode)),
        .trig_chan    (trig_chan),
        .din          (din),
        .word_valid   (word_valid),
        .word         (word),
        .capture_done (capture_done)
    );

    burst_writer u_writer (
        .clk_ip       (clk_ip),
        .rst_n        (rst_n),
        .word_valid   (word_valid),
        .word         (word),
        .capture_done (capture_done),
        .read_done    (read_done),
        .wr_ptr       (wr_ptr),
        .flushed      (flushed),
        .store        (store_bus)
    );

    burst_reader u_reader (
        .clk_ip       (clk_ip),
        .rst_n        (rst_n),
        .wr_ptr       (wr_ptr),
        .flushed      (flushed),
        .out_credit   (out_credit),
        .read_done    (read_done),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .read_idle    (read_idle),
        .store        (store_bus)
    );

    sample_store u_store (
        .clk_ip       (clk_ip),
        .bus          (store_bus)
    );

endmodule

`default_nettype wire

// File: design/sample_capture.sv
`default_nettype none

`include "la_cfg.svh"

module sample_capture (
    input  wire                            clk_ip,
    input  wire                            rst_n,
    input  wire                            sample_run,
    input  wire                            read_done,
    input  wire la_types_pkg::rate_div_t   rate_div,
    input  wire la_types_pkg::sample_cnt_t sample_num,
    input  wire la_ctrl_pkg::trig_mode_e   trig_mode,
    input  wire la_types_pkg::chan_sel_t   trig_chan,
    input  wire la_types_pkg::sample_t     din,
    output logic                           word_valid,
    output la_types_pkg::word_t            word,
    output logic                           capture_done
);
    import la_types_pkg::*;
    import la_ctrl_pkg::*;

    localparam int LANE_W = $clog2(`LA_SAMPLES_PER_WORD);

    cap_state_e        state;
    rate_div_t         div_cnt;
    sample_cnt_t       smp_cnt;
    word_t             pack_buf;
    word_t             pack_next;
    logic              prev_bit;
    logic              have_prev;
    logic              cur_bit;
    logic              sampling;
    logic              tick;
    logic              trig_hit;
    logic              take;
    logic              last;
    logic              word_end;
    logic [LANE_W-1:0] lane;

    assign cur_bit      = din[trig_chan];
    assign sampling     = (state == CAP_ARMED) || (state == CAP_RUN);
    assign tick         = sampling && (div_cnt == '0);  // first tick on the arming cycle
    assign lane         = smp_cnt[LANE_W-1:0];
    assign last         = (smp_cnt + 1'b1) == sample_num;
    assign capture_done = (state == CAP_DONE);

    always_comb begin
        case (trig_mode)
            IMMEDIATE: trig_hit = 1'b1;
            RISING:    trig_hit = have_prev && !prev_bit && cur_bit;
            FALLING:   trig_hit = have_prev && prev_bit && !cur_bit;
            default:   trig_hit = cur_bit;
        endcase
    end

    // the triggering sample is the first one kept
    assign take     = tick && ((state == CAP_RUN) || trig_hit);
    assign word_end = take && ((lane == LANE_W'(`LA_SAMPLES_PER_WORD - 1)) || last);

    always_comb begin
        pack_next = pack_buf;
        pack_next[lane*`LA_SAMPLE_W +: `LA_SAMPLE_W] = din;  // low byte first
    end

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CAP_IDLE;
            div_cnt   <= '0;
            smp_cnt   <= '0;
            prev_bit  <= 1'b0;
            have_prev <= 1'b0;
        end else if (read_done) begin
            state     <= CAP_IDLE;
            div_cnt   <= '0;
            smp_cnt   <= '0;
            prev_bit  <= 1'b0;
            have_prev <= 1'b0;
        end else begin
            case (state)
                CAP_IDLE:  if (sample_run) state <= CAP_ARMED;
                CAP_ARMED: if (take) state <= last ? CAP_DONE : CAP_RUN;
                CAP_RUN:   if (take && last) state <= CAP_DONE;
                default:   ;  // hold until read_done
            endcase
            if (sampling) begin
                div_cnt <= (div_cnt == rate_div) ? '0 : div_cnt + 1'b1;
            end
            if (tick) begin
                prev_bit  <= cur_bit;
                have_prev <= 1'b1;
            end
            if (take) smp_cnt <= smp_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            word_valid <= 1'b0;
            pack_buf   <= '0;
        end else if (read_done) begin
            word_valid <= 1'b0;
            pack_buf   <= '0;
        end else begin
            word_valid <= word_end;
            if (take) pack_buf <= word_end ? '0 : pack_next;  // zeros pad a short word
        end
    end

    always_ff @(posedge clk_ip) begin
        if (word_end) word <= pack_next;
    end

    assert property (@(posedge clk_ip) disable iff (!rst_n)
        $rose(word_valid) |-> state != CAP_IDLE);

endmodule

`default_nettype wire

// File: design/sample_store.sv
`default_nettype none

`include "la_cfg.svh"

module sample_store (
    input wire     clk_ip,
    store_if.store bus
);
    import la_types_pkg::*;

    word_t mem [`LA_STORE_DEPTH];

    always_ff @(posedge clk_ip) begin
        if (bus.wr_en) mem[bus.wr_addr] <= bus.wr_data;
    end

    // registered read port
    always_ff @(posedge clk_ip) begin
        bus.rd_valid <= bus.rd_en;
        if (bus.rd_en) bus.rd_data <= mem[bus.rd_addr];
    end

    // reader stays below the write pointer
    assert property (@(posedge clk_ip)
        (bus.wr_en && bus.rd_en) |-> (bus.wr_addr != bus.rd_addr));

endmodule

`default_nettype wire

// File: design/store_if.sv
`default_nettype none

interface store_if;
    import la_types_pkg::*;

    // write side
    logic  wr_en;
    addr_t wr_addr;
    word_t wr_data;

    // read data comes back one cycle after rd_en
    logic  rd_en;
    addr_t rd_addr;
    word_t rd_data;
    logic  rd_valid;

    modport writer (
        output wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_en, rd_addr,
        input  rd_data, rd_valid
    );

    modport store (
        input  wr_en, wr_addr, wr_data,
        input  rd_en, rd_addr,
        output rd_data, rd_valid
    );

endinterface

`default_nettype wire

// File: list.f
+incdir+design
design/la_types_pkg.sv
design/la_ctrl_pkg.sv
design/store_if.sv
design/sample_capture.sv
design/burst_writer.sv
design/burst_reader.sv
design/sample_store.sv
design/logic_analyzer_top.sv
testbench/tb_logic_analyzer.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_logic_analyzer -f list.f

# a crash still leaves its output for the search below
out=$(./obj_dir/Vtb_logic_analyzer) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q '^RESULT: PASS$'

// File: testbench/tb_logic_analyzer.sv
`default_nettype none

`include "la_cfg.svh"

module tb_logic_analyzer;
    timeunit 1ns;
    timeprecision 1ps;

    import la_types_pkg::*;

    localparam int STIM_WORDS = 512;

    logic        clk_ip = 1'b0;
    logic        rst_n;
    logic        sample_run;
    logic        read_done;
    rate_div_t   rate_div;
    sample_cnt_t sample_num;
    logic [1:0]  trig_mode;
    chan_sel_t   trig_chan;
    sample_t     din;
    logic        out_credit;
    logic        out_valid;
    word_t       out_data;
    logic        capture_done;
    logic        read_idle;

    logic [31:0] stim [STIM_WORDS];
    word_t       exp_q [$];     // every word expected so far, in order
    int          due_q [$];     // cycles at which credits go back
    int          cycle_limit = 0;
    int          cyc = 0;
    int          rcv_cnt = 0;
    int          outstanding = 0;
    int          errors = 0;
    int          checks = 0;
    int          mon_errors = 0;
    int          mon_checks = 0;

    always #50 clk_ip = ~clk_ip;  // 100 ns period

    logic_analyzer_top DUT (
        .clk_ip       (clk_ip),
        .rst_n        (rst_n),
        .sample_run   (sample_run),
        .read_done    (read_done),
        .rate_div     (rate_div),
        .sample_num   (sample_num),
        .trig_mode    (trig_mode),
        .trig_chan    (trig_chan),
        .din          (din),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .capture_done (capture_done),
        .read_idle    (read_idle)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic expect_bit(input string name, input logic got, input logic want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("[ERROR] %0d ns %s expected %b got %b", $time, name, want, got);
        end
    endtask

    task automatic run_case(input int pos, output int next_pos);
        int n_din;
        int n_exp;
        int k;
        n_din = int'(stim[pos + 4]);
        n_exp = int'(stim[pos + 5]);
        for (k = 0; k < n_exp; k++) begin
            exp_q.push_back(stim[pos + 6 + n_din + k]);
        end
        @(negedge clk_ip);
        trig_mode  = stim[pos][1:0];
        trig_chan  = chan_sel_t'(stim[pos + 1]);
        rate_div   = rate_div_t'(stim[pos + 2]);
        sample_num = sample_cnt_t'(stim[pos + 3]);
        din        = '0;
        sample_run = 1'b1;
        for (k = 0; k < n_din; k++) begin
            @(negedge clk_ip);
            sample_run = 1'b0;
            din = sample_t'(stim[pos + 6 + k]);  // din index 0 is the arming cycle
        end
        @(negedge clk_ip);
        din = '0;
        // readout is over once the store is drained too
        while (!(capture_done && read_idle)) @(negedge clk_ip);
        checks++;
        assert (rcv_cnt == exp_q.size()) else begin
            errors++;
            $display("readout delivered %0d words in total where %0d were expected",
                     rcv_cnt, exp_q.size());
        end
        read_done = 1'b1;
        @(negedge clk_ip);
        read_done = 1'b0;
        expect_bit("capture_done", capture_done, 1'b0);
        expect_bit("read_idle", read_idle, 1'b0);
        next_pos = pos + 6 + n_din + n_exp;
    endtask

    initial begin
        int pos;
        int c;
        int n_cases;
        int total_din;
        int total_exp;
        int total_err;
        rst_n      = 1'b0;
        sample_run = 1'b0;
        read_done  = 1'b0;
        rate_div   = '0;
        sample_num = '0;
        trig_mode  = 2'b00;
        trig_chan  = '0;
        din        = '0;
        $readmemh("testbench/tb_stimulus.txt", stim);
        n_cases   = int'(stim[0]);
        pos       = 1;
        total_din = 0;
        total_exp = 0;
        for (c = 0; c < n_cases; c++) begin
            total_din += int'(stim[pos + 4]);
            total_exp += int'(stim[pos + 5]);
            pos += 6 + int'(stim[pos + 4]) + int'(stim[pos + 5]);
        end
        cycle_limit = total_din + 64 * total_exp + 500;

        repeat (16) @(negedge clk_ip);
        rst_n = 1'b1;
        @(negedge clk_ip);
        expect_bit("out_valid", out_valid, 1'b0);
        expect_bit("capture_done", capture_done, 1'b0);
        expect_bit("read_idle", read_idle, 1'b0);

        pos = 1;
        for (c = 0; c < n_cases; c++) begin
            run_case(pos, pos);
        end

        total_err = errors + mon_errors;
        $display("%0d cases, %0d checks, %0d errors", n_cases, checks + mon_checks, total_err);
        if (total_err == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // consumer model checks each word and hands its credit back after a random delay
    initial begin
        logic [31:0] rng;
        int          due;
        out_credit = 1'b0;
        rng        = 32'd82631;
        forever begin
            @(negedge clk_ip);
            if (rst_n && out_valid) begin
                mon_checks++;
                assert (rcv_cnt < exp_q.size()) else begin
                    mon_errors++;
                    $display("word %h at %0d ns came after the end of the readout",
                             out_data, $time);
                end
                if (rcv_cnt < exp_q.size()) begin
                    mon_checks++;
                    assert (out_data === exp_q[rcv_cnt]) else begin
                        mon_errors++;
                        $display("[ERROR] %0d ns out_data expected %h got %h",
                                 $time, exp_q[rcv_cnt], out_data);
                    end
                end
                rcv_cnt++;
                outstanding++;
                mon_checks++;
                assert (outstanding <= `LA_OUT_CREDITS) else begin
                    mon_errors++;
                    $display("out_valid at %0d ns while no credit was left", $time);
                end
                rng = next_rand(rng);
                due = cyc + int'(rng[3:0]) + 1;
                if (due_q.size() > 0 && due <= due_q[$]) due = due_q[$] + 1;
                due_q.push_back(due);
            end
            if (due_q.size() > 0 && due_q[0] <= cyc) begin  // one credit per cycle
                out_credit = 1'b1;
                outstanding--;
                void'(due_q.pop_front());
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cyc < cycle_limit) begin
            @(posedge clk_ip);
            cyc++;
        end
        $display("timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_stimulus.txt
// case line: trig_mode trig_chan rate_div sample_num din_count word_count, all hex
// then din_count din bytes, one per cycle after sample_run, then word_count out_data words
05
// immediate, every cycle
0 0 0 8 8 2
11 22 33 44 55 66 77 88
44332211 88776655
// rising edge on channel 3, short last word
1 3 0 6 B 2
08 00 00 0A 1C 25 30 4F 5B 6E 77
30251C0A 00005B4F
// falling edge on channel 7, tick every 2nd cycle
2 7 1 4 C 1
80 00 81 7F 12 EE 34 EE 56 EE 78 EE
78563412
// high level on channel 1, tick every 3rd cycle
3 1 2 5 13 2
01 02 03 A4 FF FF B2 00 00 C3 00 00 D4 00 00 E5 00 00 F6
E5D4C3B2 000000F6
// immediate, long enough to run out of credits
0 0 0 28 28 A
10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F
30 31 32 33 34 35 36 37
13121110 17161514 1B1A1918 1F1E1D1C 23222120
27262524 2B2A2928 2F2E2D2C 33323130 37363534
